//--- hw/wb_pt_consts.svh
// ##############################
// Wishbone subsystem constants
// Bus widths, address windows, SRAM depth and ID value
// ##############################

`ifndef WB_PT_CONSTS_SVH
`define WB_PT_CONSTS_SVH

// Bus widths
`define WB_PT_ADDR_W 32
`define WB_PT_DATA_W 32
`define WB_PT_SEL_W (`WB_PT_DATA_W / 8)

// Control-register window, four words
`define WB_PT_REGS_BASE 32'h0000_0000
`define WB_PT_REGS_LIMIT 32'h0000_000F

// SRAM window, 4 KiB
`define WB_PT_SRAM_BASE 32'h0000_1000
`define WB_PT_SRAM_LIMIT 32'h0000_1FFF

// SRAM word-address bits
`define WB_PT_SRAM_AW 10

// Read-only identification word, "WBPT" in ASCII
`define WB_PT_ID 32'h5742_5054

`endif

//--- hw/wb_pt_pkg.sv
// ##############################
// Wishbone subsystem types
// Target select and register index enums
// ##############################

package wb_pt_pkg;

	// Target latched by the interconnect for one cycle
	typedef enum logic [1:0] {
		TGT_REGS = 2'd0,
		TGT_SRAM = 2'd1,
		// Decode-fail responder inside the interconnect
		TGT_ERR  = 2'd2,
		// No cycle in progress
		TGT_NONE = 2'd3
	} tgt_sel_t;

	// Word index inside the control-register block, adr[3:2]
	typedef enum logic [1:0] {
		REG_ID      = 2'd0,
		REG_SCRATCH = 2'd1,
		REG_WRCNT   = 2'd2,
		REG_RSVD    = 2'd3
	} reg_idx_t;

endpackage

//--- hw/wb_if.sv
// ##############################
// Wishbone classic bus interface
// Single transfers, no CTI or BTE
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

interface wb_if;

	// Request side
	logic [`WB_PT_ADDR_W-1:0] adr;
	logic [`WB_PT_DATA_W-1:0] dat_w;
	logic [`WB_PT_SEL_W-1:0]  sel;
	logic                     we;
	logic                     cyc;
	logic                     stb;

	// Response side
	logic [`WB_PT_DATA_W-1:0] dat_r;
	logic                     ack;
	logic                     err;

	// Held by whoever issues cycles
	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input  dat_r, ack, err
	);

	// Held by whoever answers cycles
	modport slave (
		input  adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack, err
	);

endinterface

//--- hw/wb_interconnect_1x2_pt.sv
// ##############################
// Wishbone interconnect, one master to two slaves
// Decodes the address, latches the target for the cycle,
// routes the request and returns the response
// Unmapped addresses get ERR from a local responder
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

module wb_interconnect_1x2_pt (
	input  logic clk,
	input  logic rstn,
	wb_if.slave  m,
	wb_if.master s0,
	wb_if.master s1
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_t;

	state_t                   state_q;
	wb_pt_pkg::tgt_sel_t      tgt_q;
	wb_pt_pkg::tgt_sel_t      tgt_dec;
	logic                     req;
	logic                     derr_q;
	logic                     rsp_ack;
	logic                     rsp_err;
	logic [`WB_PT_DATA_W-1:0] rsp_dat;

	assign req = m.cyc && m.stb;

	// Window compare on the live address, only sampled in IDLE
	always_comb begin
		if (m.adr >= `WB_PT_REGS_BASE && m.adr <= `WB_PT_REGS_LIMIT) begin
			tgt_dec = wb_pt_pkg::TGT_REGS;
		end else if (m.adr >= `WB_PT_SRAM_BASE && m.adr <= `WB_PT_SRAM_LIMIT) begin
			tgt_dec = wb_pt_pkg::TGT_SRAM;
		end else begin
			tgt_dec = wb_pt_pkg::TGT_ERR;
		end
	end

	// Target stays fixed from the strobe until ack or err
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			tgt_q   <= wb_pt_pkg::TGT_NONE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req) begin
						state_q <= ST_BUSY;
						tgt_q   <= tgt_dec;
					end
				end
				ST_BUSY: begin
					// One response ends the transfer
					if (rsp_ack || rsp_err) begin
						state_q <= ST_IDLE;
						tgt_q   <= wb_pt_pkg::TGT_NONE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
					tgt_q   <= wb_pt_pkg::TGT_NONE;
				end
			endcase
		end
	end

	// Decode-fail responder
	// Err one cycle into BUSY, same latency as a real slave
	always_ff @(posedge clk) begin
		if (!rstn) begin
			derr_q <= 1'b0;
		end else begin
			derr_q <= (state_q == ST_BUSY) && (tgt_q == wb_pt_pkg::TGT_ERR) && req && !derr_q;
		end
	end

	// Request mux, the unselected bus sees all zeros
	always_comb begin
		s0.adr   = '0;
		s0.dat_w = '0;
		s0.sel   = '0;
		s0.we    = 1'b0;
		s0.cyc   = 1'b0;
		s0.stb   = 1'b0;
		s1.adr   = '0;
		s1.dat_w = '0;
		s1.sel   = '0;
		s1.we    = 1'b0;
		s1.cyc   = 1'b0;
		s1.stb   = 1'b0;
		if (state_q == ST_BUSY) begin
			if (tgt_q == wb_pt_pkg::TGT_REGS) begin
				s0.adr   = m.adr;
				s0.dat_w = m.dat_w;
				s0.sel   = m.sel;
				s0.we    = m.we;
				s0.cyc   = m.cyc;
				s0.stb   = m.stb;
			end else if (tgt_q == wb_pt_pkg::TGT_SRAM) begin
				s1.adr   = m.adr;
				s1.dat_w = m.dat_w;
				s1.sel   = m.sel;
				s1.we    = m.we;
				s1.cyc   = m.cyc;
				s1.stb   = m.stb;
			end
		end
	end

	// Response mux, zeros when nothing is selected
	always_comb begin
		case (tgt_q)
			wb_pt_pkg::TGT_REGS: begin
				rsp_dat = s0.dat_r;
				rsp_ack = s0.ack;
				rsp_err = s0.err;
			end
			wb_pt_pkg::TGT_SRAM: begin
				rsp_dat = s1.dat_r;
				rsp_ack = s1.ack;
				rsp_err = s1.err;
			end
			wb_pt_pkg::TGT_ERR: begin
				rsp_dat = '0;
				rsp_ack = 1'b0;
				rsp_err = derr_q;
			end
			default: begin
				rsp_dat = '0;
				rsp_ack = 1'b0;
				rsp_err = 1'b0;
			end
		endcase
	end

	assign m.dat_r = rsp_dat;
	assign m.ack   = rsp_ack;
	assign m.err   = rsp_err;

endmodule

//--- hw/wb_ctrl_regs.sv
// ##############################
// Control-register slave
// ID, scratch and write counter, ERR on illegal access
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

module wb_ctrl_regs (
	input  logic clk,
	input  logic rstn,
	wb_if.slave  bus
);

	wb_pt_pkg::reg_idx_t      idx;
	logic                     req;
	logic                     legal;
	logic                     ack_q;
	logic                     err_q;
	logic [`WB_PT_DATA_W-1:0] scratch_q;
	logic [`WB_PT_DATA_W-1:0] wrcnt_q;
	logic [`WB_PT_DATA_W-1:0] rd_data;
	logic [`WB_PT_DATA_W-1:0] dat_r_q;

	// Word index from the byte address
	assign idx = wb_pt_pkg::reg_idx_t'(bus.adr[3:2]);

	// A strobe already answered last cycle is not taken again
	assign req = bus.cyc && bus.stb && !ack_q && !err_q;

	// ID and counter are read-only, reserved word rejects everything
	always_comb begin
		case (idx)
			wb_pt_pkg::REG_ID:      legal = !bus.we;
			wb_pt_pkg::REG_SCRATCH: legal = 1'b1;
			wb_pt_pkg::REG_WRCNT:   legal = !bus.we;
			default:                legal = 1'b0;
		endcase
	end

	// Read mux
	always_comb begin
		case (idx)
			wb_pt_pkg::REG_ID:      rd_data = `WB_PT_ID;
			wb_pt_pkg::REG_SCRATCH: rd_data = scratch_q;
			wb_pt_pkg::REG_WRCNT:   rd_data = wrcnt_q;
			default:                rd_data = '0;
		endcase
	end

	// Response pulses and the write counter
	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q   <= 1'b0;
			err_q   <= 1'b0;
			wrcnt_q <= '0;
		end else begin
			ack_q <= req && legal;
			err_q <= req && !legal;
			// Only acknowledged writes count, wraps at full width
			if (req && legal && bus.we) begin
				wrcnt_q <= wrcnt_q + 1'b1;
			end
		end
	end

	// Scratch byte lanes and registered read data
	always_ff @(posedge clk) begin
		if (req && legal && bus.we) begin
			for (int b = 0; b < `WB_PT_SEL_W; b++) begin
				if (bus.sel[b]) begin
					scratch_q[b*8 +: 8] <= bus.dat_w[b*8 +: 8];
				end
			end
		end
		// Zero data with err
		dat_r_q <= (req && legal) ? rd_data : '0;
	end

	assign bus.dat_r = dat_r_q;
	assign bus.ack   = ack_q;
	assign bus.err   = err_q;

endmodule

//--- hw/wb_sram_slave.sv
// ##############################
// Wishbone SRAM slave
// Word-addressed, byte selects, registered ack
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

module wb_sram_slave #(
	parameter int AW = `WB_PT_SRAM_AW
) (
	input  logic clk,
	input  logic rstn,
	wb_if.slave  bus
);

	logic [`WB_PT_DATA_W-1:0] mem [0:(2**AW)-1];
	logic [AW-1:0]            widx;
	logic                     req;
	logic                     ack_q;
	logic [`WB_PT_DATA_W-1:0] dat_r_q;

	// Word index, byte offset bits dropped
	assign widx = bus.adr[AW+1:2];

	// Held off in the ack cycle so each strobe gets one pulse
	assign req = bus.cyc && bus.stb && !ack_q;

	// Memory array, contents survive reset
	always_ff @(posedge clk) begin
		if (req && bus.we) begin
			for (int b = 0; b < `WB_PT_SEL_W; b++) begin
				if (bus.sel[b]) begin
					mem[widx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
				end
			end
		end
		// Read data lands with ack
		if (req) begin
			dat_r_q <= mem[widx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	assign bus.dat_r = dat_r_q;
	assign bus.ack   = ack_q;
	// Every mapped word is valid
	assign bus.err   = 1'b0;

endmodule

//--- hw/wb_pt_subsys.sv
// ##############################
// Wishbone subsystem top level
// One master port, register block and SRAM behind an interconnect
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

module wb_pt_subsys (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [`WB_PT_ADDR_W-1:0] wb_adr_i,
	input  logic [`WB_PT_DATA_W-1:0] wb_dat_i,
	input  logic [`WB_PT_SEL_W-1:0]  wb_sel_i,
	input  logic                     wb_we_i,
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	output logic [`WB_PT_DATA_W-1:0] wb_dat_o,
	output logic                     wb_ack_o,
	output logic                     wb_err_o
);

	wb_if m_bus ();
	wb_if regs_bus ();
	wb_if sram_bus ();

	// External master onto the internal bus
	assign m_bus.adr   = wb_adr_i;
	assign m_bus.dat_w = wb_dat_i;
	assign m_bus.sel   = wb_sel_i;
	assign m_bus.we    = wb_we_i;
	assign m_bus.cyc   = wb_cyc_i;
	assign m_bus.stb   = wb_stb_i;
	assign wb_dat_o    = m_bus.dat_r;
	assign wb_ack_o    = m_bus.ack;
	assign wb_err_o    = m_bus.err;

	wb_interconnect_1x2_pt xbar0 (
		.clk  (clk),
		.rstn (rstn),
		.m    (m_bus.slave),
		.s0   (regs_bus.master),
		.s1   (sram_bus.master)
	);

	// Slave 0, control registers
	wb_ctrl_regs regs0 (
		.clk  (clk),
		.rstn (rstn),
		.bus  (regs_bus.slave)
	);

	// Slave 1, SRAM sized to fill its window
	wb_sram_slave #(
		.AW (`WB_PT_SRAM_AW)
	) sram0 (
		.clk  (clk),
		.rstn (rstn),
		.bus  (sram_bus.slave)
	);

endmodule

//--- tests/tb_wb_pt.sv
// ##############################
// Testbench for the Wishbone subsystem
// Replays golden transactions and checks data, response and latency
// ##############################

`timescale 1ns/1ns
`include "wb_pt_consts.svh"

module tb_wb_pt;

	localparam int CLK_PERIOD  = 20;
	localparam int RSP_TIMEOUT = 20;
	// Cycles from the strobe edge to the response
	localparam int RSP_LATENCY = 2;

	logic                     clk;
	logic                     rstn;
	logic [`WB_PT_ADDR_W-1:0] wb_adr_i;
	logic [`WB_PT_DATA_W-1:0] wb_dat_i;
	logic [`WB_PT_SEL_W-1:0]  wb_sel_i;
	logic                     wb_we_i;
	logic                     wb_cyc_i;
	logic                     wb_stb_i;
	logic [`WB_PT_DATA_W-1:0] wb_dat_o;
	logic                     wb_ack_o;
	logic                     wb_err_o;

	int err_cnt;
	int timeout_cnt;
	int txn_cnt;
	// Acknowledged register writes seen so far in the golden sequence
	int reg_wr_cnt;

	wb_pt_subsys dut0 (
		.clk      (clk),
		.rstn     (rstn),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.wb_err_o (wb_err_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		if (act !== exp) begin
			$display("ERR %s txn %0d: got 0x%08h, expected 0x%08h",
				name, txn_cnt, act, exp);
			err_cnt++;
		end
	endtask

	// Address map from the two windows
	function automatic wb_pt_pkg::tgt_sel_t ref_target(input logic [31:0] adr);
		if (adr >= `WB_PT_REGS_BASE && adr <= `WB_PT_REGS_LIMIT) begin
			return wb_pt_pkg::TGT_REGS;
		end else if (adr >= `WB_PT_SRAM_BASE && adr <= `WB_PT_SRAM_LIMIT) begin
			return wb_pt_pkg::TGT_SRAM;
		end
		return wb_pt_pkg::TGT_ERR;
	endfunction

	// Read-only words reject writes and the reserved word rejects all
	function automatic logic ref_expect_err(input logic [31:0] adr, input logic we);
		wb_pt_pkg::reg_idx_t idx;
		idx = wb_pt_pkg::reg_idx_t'(adr[3:2]);
		case (ref_target(adr))
			wb_pt_pkg::TGT_REGS: begin
				case (idx)
					wb_pt_pkg::REG_ID:      return we;
					wb_pt_pkg::REG_SCRATCH: return 1'b0;
					wb_pt_pkg::REG_WRCNT:   return we;
					default:                return 1'b1;
				endcase
			end
			wb_pt_pkg::TGT_SRAM: return 1'b0;
			default:             return 1'b1;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// No response may appear without a strobe
	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("wb_ack_o", wb_ack_o, 1'b0);
			check_value("wb_err_o", wb_err_o, 1'b0);
		end
	endtask

	// One classic cycle with the response sampled mid-cycle
	task automatic run_txn(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
			input logic [3:0] sel, input logic [31:0] exp_rdata, input logic exp_err);
		int   cnt;
		logic got;
		cnt = 0;
		got = 1'b0;
		@(posedge clk);
		wb_adr_i <= adr;
		wb_dat_i <= wdata;
		wb_sel_i <= sel;
		wb_we_i  <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		while (!got && cnt < RSP_TIMEOUT) begin
			@(negedge clk);
			if (wb_ack_o || wb_err_o) begin
				got = 1'b1;
			end else begin
				cnt++;
			end
		end
		if (!got) begin
			$display("Timeout: no ack or err within %0d cycles for transaction %0d at 0x%08h",
				RSP_TIMEOUT, txn_cnt, adr);
			timeout_cnt++;
		end else begin
			check_value("response latency", cnt, RSP_LATENCY);
			check_value("wb_ack_o", wb_ack_o, !exp_err);
			check_value("wb_err_o", wb_err_o, exp_err);
			// Write data phase returns no defined data on ack
			if (!we || exp_err) begin
				check_value("wb_dat_o", wb_dat_o, exp_rdata);
			end
		end
		@(posedge clk);
		wb_adr_i <= '0;
		wb_dat_i <= '0;
		wb_sel_i <= '0;
		wb_we_i  <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		// Pulse is gone one cycle later
		@(negedge clk);
		check_value("wb_ack_o", wb_ack_o, 1'b0);
		check_value("wb_err_o", wb_err_o, 1'b0);
	endtask

	initial begin
		int          fd;
		int          rc;
		int          c;
		int          gap;
		logic        bad;
		logic [63:0] op_tok;
		logic [63:0] rsp_tok;
		logic [31:0] g_adr;
		logic [31:0] g_wdata;
		logic [31:0] g_rdata;
		logic [3:0]  g_sel;
		logic        g_we;
		logic        g_err;

		void'($urandom(32'h6c56));
		err_cnt     = 0;
		timeout_cnt = 0;
		txn_cnt     = 0;
		reg_wr_cnt  = 0;
		bad         = 1'b0;
		rstn        = 1'b0;
		wb_adr_i    = '0;
		wb_dat_i    = '0;
		wb_sel_i    = '0;
		wb_we_i     = 1'b0;
		wb_cyc_i    = 1'b0;
		wb_stb_i    = 1'b0;

		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		check_quiet(5);

		fd = $fopen("tests/wb_pt_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file tests/wb_pt_golden.txt");
			err_cnt++;
		end else begin
			rc = $fscanf(fd, "%s", op_tok);
			while (rc == 1 && !bad) begin
				if (op_tok == "#") begin
					// Comment line skipped up to the newline
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end else begin
					rc = $fscanf(fd, "%h %h %h %h %s",
						g_adr, g_wdata, g_sel, g_rdata, rsp_tok);
					if (rc != 5 || (op_tok != "W" && op_tok != "R")
							|| (rsp_tok != "A" && rsp_tok != "E")) begin
						$display("Malformed golden line after transaction %0d", txn_cnt);
						err_cnt++;
						bad = 1'b1;
					end else begin
						g_we  = (op_tok == "W");
						g_err = (rsp_tok == "E");
						txn_cnt++;
						if (ref_expect_err(g_adr, g_we) != g_err) begin
							$display("Golden transaction %0d disagrees with the address map",
								txn_cnt);
							err_cnt++;
						end
						if (ref_target(g_adr) == wb_pt_pkg::TGT_REGS && !g_we && !g_err
								&& g_adr[3:2] == wb_pt_pkg::REG_WRCNT
								&& g_rdata != reg_wr_cnt) begin
							$display("Golden transaction %0d expects a write count other than %0d",
								txn_cnt, reg_wr_cnt);
							err_cnt++;
						end
						gap = $urandom % 4;
						idle_cycles(gap);
						run_txn(g_we, g_adr, g_wdata, g_sel, g_rdata, g_err);
						if (ref_target(g_adr) == wb_pt_pkg::TGT_REGS && g_we && !g_err) begin
							reg_wr_cnt++;
						end
					end
				end
				if (!bad) begin
					rc = $fscanf(fd, "%s", op_tok);
				end
			end
			$fclose(fd);
		end

		if (txn_cnt == 0) begin
			$display("No transactions were run from the golden file");
			err_cnt++;
		end
		check_quiet(3);

		$display("Transactions %0d, mismatches %0d, timeouts %0d",
			txn_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tests/wb_pt_golden.txt
# op adr wdata sel rdata resp, all hex, op W or R, resp A for ack or E for err
# rdata is compared on reads and on err, it is ignored for acknowledged writes
W 00001000 11223344 f 00000000 A
W 00001ffc a5a5a5a5 f 00000000 A
W 00001ffc 0000be00 2 00000000 A
R 00001000 00000000 f 11223344 A
R 00001ffc 00000000 f a5a5bea5 A
W 00001000 ff000000 8 00000000 A
W 00001000 000000cc 1 00000000 A
R 00001000 00000000 f ff2233cc A
W 00001800 01020304 f 00000000 A
W 00001800 0000aa00 6 00000000 A
R 00001800 00000000 f 0100aa04 A
R 00000000 00000000 f 57425054 A
R 00000008 00000000 f 00000000 A
W 00000004 cafef00d f 00000000 A
W 00000004 00001200 2 00000000 A
W 00000004 77000000 8 00000000 A
R 00000004 00000000 f 77fe120d A
W 00000000 12345678 f 00000000 E
R 00000000 00000000 f 57425054 A
W 00000008 00000009 f 00000000 E
R 0000000c 00000000 f 00000000 E
W 0000000c 00000001 f 00000000 E
R 00000008 00000000 f 00000003 A
R 00000004 00000000 f 77fe120d A
R 00000800 00000000 f 00000000 E
W 80000000 12345678 f 00000000 E
R 80000000 00000000 f 00000000 E
R 00000010 00000000 f 00000000 E
R 00002000 00000000 f 00000000 E
R 00001ffc 00000000 f a5a5bea5 A

//--- wb_pt.f
+incdir+hw
hw/wb_pt_pkg.sv
hw/wb_if.sv
hw/wb_interconnect_1x2_pt.sv
hw/wb_ctrl_regs.sv
hw/wb_sram_slave.sv
hw/wb_pt_subsys.sv
tests/tb_wb_pt.sv

//--- Bender.yml
package:
  name: wb_pt

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_pt_pkg.sv
      - hw/wb_if.sv
      - hw/wb_interconnect_1x2_pt.sv
      - hw/wb_ctrl_regs.sv
      - hw/wb_sram_slave.sv
      - hw/wb_pt_subsys.sv
  - target: test
    files:
      - tests/tb_wb_pt.sv
